// ==== flist.f ====
cache_pkg.sv
cache_tags.sv
cache_data.sv
mem_req_queue.sv
bank_ctrl.sv
cache_bank.sv
cache_bank_sva.sv
cache_checker.sv
tb_cache_bank.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_cache_bank
FLIST = flist.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: compile
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== tb_cache_bank.sv ====
`timescale 1ns/100ps

module tb_cache_bank;
    import cache_pkg::*;

    localparam int num_reqs       = 400;
    localparam int timeout_cycles = num_reqs * 20 + num_lines + 10;

    logic                  clk;
    logic                  rst_n;
    logic                  core_req_valid;
    core_req_t             core_req;
    logic                  core_req_ready;
    logic                  core_rsp_valid;
    core_rsp_t             core_rsp;
    logic                  core_rsp_ready;
    logic                  mem_req_valid;
    mem_req_t              mem_req;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    logic [line_width-1:0] mem_rsp_data;
    logic                  mem_rsp_ready;

    // memory model, fills answered in order
    logic [line_width-1:0]      mem [1 << line_addr_width];
    logic [line_addr_width-1:0] fill_q [$];
    int                         fill_delay;

    integer      seed;
    int          issued;
    logic [31:0] r;
    logic        req_fire;
    logic        mreq_fire;
    logic        mrsp_fire;
    mem_req_t    mreq_now;
    logic        done;
    int          err_count;
    int          pending;

    cache_bank uut (.*);

    cache_checker u_chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .done           (done),
        .errors         (err_count),
        .pending        (pending)
    );

    function automatic logic [line_width-1:0] init_line(input int a);
        logic [line_width-1:0] l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*word_width +: word_width] = {a[9:0], w[1:0], ~a[9:0], 10'(w * 97 + 5)};
        end
        return l;
    endfunction

    task automatic write_mem(input mem_req_t req);
        for (int b = 0; b < line_bytes; b++) begin
            if (req.byteen[b]) begin
                mem[req.addr][b*8 +: 8] = req.data[b*8 +: 8];
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    // all stimulus from one process, 1 ns after the edge
    initial begin
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b0;
        mem_req_ready  = 1'b0;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        issued         = 0;
        fill_delay     = 0;
        seed           = 63;
        for (int a = 0; a < (1 << line_addr_width); a++) begin
            mem[a] = init_line(a);
        end
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            req_fire  = core_req_valid && core_req_ready;
            mreq_fire = mem_req_valid && mem_req_ready;
            mrsp_fire = mem_rsp_valid && mem_rsp_ready;
            mreq_now  = mem_req;
            #1;
            if (mreq_fire) begin
                if (mreq_now.rw) begin
                    write_mem(mreq_now);
                end else begin
                    fill_q.push_back(mreq_now.addr);
                    fill_delay = 1 + (($random(seed) & 32'h7fff_ffff) % 5);
                end
            end
            if (mrsp_fire) begin
                mem_rsp_valid = 1'b0;
                void'(fill_q.pop_front());
            end
            if (fill_q.size() != 0 && !mem_rsp_valid) begin
                if (fill_delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = mem[fill_q[0]];
                end else begin
                    fill_delay--;
                end
            end
            if (req_fire || !core_req_valid) begin
                core_req_valid = 1'b0;
                if (issued < num_reqs && ($random(seed) & 3) != 0) begin
                    // two tags per index, 32 lines in use
                    r = $random(seed);
                    core_req.addr   = {(r[4] ? 6'h2a : 6'h15), r[3:0]};
                    core_req.rw     = (r[7:5] < 3'd3);
                    core_req.wsel   = r[9:8];
                    core_req.byteen = r[13:10];
                    core_req.data   = $random(seed);
                    core_req.tag    = issued[7:0];
                    core_req_valid  = 1'b1;
                    issued++;
                end
            end
            core_rsp_ready = ($random(seed) & 3) != 0;
            mem_req_ready  = (($random(seed) & 32'h7fff_ffff) % 5) != 0;
        end
    end

    initial begin
        done = 1'b0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        while (issued < num_reqs || core_req_valid || pending != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        done = 1'b1;
        #1;
        if (err_count == 0 && uut.u_sva.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_cycles * 10);
        $display("watchdog: run did not finish in %0d cycles, DUT appears hung", timeout_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== cache_checker.sv ====
`timescale 1ns/100ps

module cache_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 core_req_valid,
    input  cache_pkg::core_req_t core_req,
    input  logic                 core_req_ready,
    input  logic                 core_rsp_valid,
    input  cache_pkg::core_rsp_t core_rsp,
    input  logic                 core_rsp_ready,
    input  logic                 mem_req_valid,
    input  cache_pkg::mem_req_t  mem_req,
    input  logic                 mem_req_ready,
    input  logic                 done,
    output int                   errors,
    output int                   pending
);
    import cache_pkg::*;

    typedef struct packed {
        logic [word_width-1:0]    data;
        logic [req_tag_width-1:0] tag;
        logic                     hit;
        logic [31:0]              cycle;
        logic [31:0]              stalls;
    } rsp_exp_t;

    // reference memory and tag state
    logic [line_width-1:0]    ref_mem [1 << line_addr_width];
    logic [num_lines-1:0]     ref_valid;
    logic [tag_sel_bits-1:0]  ref_tag [num_lines];
    rsp_exp_t                 rsp_q [$];
    mem_req_t                 mreq_q [$];
    rsp_exp_t                 exp_rsp;
    mem_req_t                 exp_mreq;
    logic [line_sel_bits-1:0] idx;
    logic [tag_sel_bits-1:0]  tg;
    logic [31:0]              cyc;
    logic [31:0]              stall_cnt;
    int                       checks;
    int                       reads;
    int                       writes;
    logic                     swept;
    logic                     rsp_shown;

    // same starting contents as the memory model
    function automatic logic [line_width-1:0] init_line(input int a);
        logic [line_width-1:0] l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*word_width +: word_width] = {a[9:0], w[1:0], ~a[9:0], 10'(w * 97 + 5)};
        end
        return l;
    endfunction

    task automatic compare_value(input string name, input logic [line_width-1:0] exp_v,
                                 input logic [line_width-1:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("ERROR %s expected %0h actual %0h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    initial begin
        for (int a = 0; a < (1 << line_addr_width); a++) begin
            ref_mem[a] = init_line(a);
        end
        ref_valid = '0;
        errors    = 0;
        pending   = 0;
        checks    = 0;
        reads     = 0;
        writes    = 0;
        cyc       = '0;
        stall_cnt = '0;
        swept     = 1'b0;
        rsp_shown = 1'b0;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (!swept) begin
                if (core_rsp_valid || mem_req_valid) begin
                    errors++;
                    $display("response or memory request seen before the init sweep ended");
                end
                if (core_req_ready) begin
                    swept = 1'b1;
                    compare_value("init_ready", num_lines, cyc);
                end
            end

            if (core_req_valid && core_req_ready) begin
                idx = core_req.addr[line_sel_bits-1:0];
                tg  = core_req.addr[line_addr_width-1:line_sel_bits];
                if (core_req.rw) begin
                    // write-through, byte enables land in the word's slot
                    writes++;
                    exp_mreq.rw     = 1'b1;
                    exp_mreq.addr   = core_req.addr;
                    exp_mreq.byteen = '0;
                    exp_mreq.data   = {words_per_line{core_req.data}};
                    for (int b = 0; b < word_bytes; b++) begin
                        exp_mreq.byteen[core_req.wsel*word_bytes + b] = core_req.byteen[b];
                        if (core_req.byteen[b]) begin
                            ref_mem[core_req.addr][(core_req.wsel*word_bytes + b)*8 +: 8] =
                                core_req.data[b*8 +: 8];
                        end
                    end
                    mreq_q.push_back(exp_mreq);
                end else begin
                    reads++;
                    exp_rsp.hit = ref_valid[idx] && (ref_tag[idx] == tg);
                    if (!exp_rsp.hit) begin
                        exp_mreq.rw     = 1'b0;
                        exp_mreq.addr   = core_req.addr;
                        exp_mreq.byteen = '1;
                        exp_mreq.data   = '0;
                        mreq_q.push_back(exp_mreq);
                        ref_valid[idx] = 1'b1;
                        ref_tag[idx]   = tg;
                    end
                    exp_rsp.data   = ref_mem[core_req.addr][core_req.wsel*word_width +: word_width];
                    exp_rsp.tag    = core_req.tag;
                    exp_rsp.cycle  = cyc;
                    exp_rsp.stalls = stall_cnt;
                    rsp_q.push_back(exp_rsp);
                end
            end

            // hit latency only counts when nothing stalled in between
            if (core_rsp_valid && rsp_q.size() != 0) begin
                if (!rsp_shown && rsp_q[0].hit && rsp_q[0].stalls == stall_cnt) begin
                    compare_value("hit_latency", 2, cyc - rsp_q[0].cycle);
                end
                rsp_shown = 1'b1;
            end
            if (core_rsp_valid && core_rsp_ready) begin
                if (rsp_q.size() == 0) begin
                    errors++;
                    $display("response with tag %0h arrived with no read outstanding",
                             core_rsp.tag);
                end else begin
                    exp_rsp = rsp_q.pop_front();
                    compare_value("read_tag", exp_rsp.tag, core_rsp.tag);
                    compare_value("read_data", exp_rsp.data, core_rsp.data);
                end
                rsp_shown = 1'b0;
            end

            if (mem_req_valid && mem_req_ready) begin
                if (mreq_q.size() == 0) begin
                    errors++;
                    $display("memory request to line %0h issued with none expected", mem_req.addr);
                end else begin
                    exp_mreq = mreq_q.pop_front();
                    compare_value("mem_rw", exp_mreq.rw, mem_req.rw);
                    compare_value("mem_addr", exp_mreq.addr, mem_req.addr);
                    compare_value("mem_byteen", exp_mreq.byteen, mem_req.byteen);
                    if (exp_mreq.rw) begin
                        compare_value("mem_data", exp_mreq.data, mem_req.data);
                    end
                end
            end

            if (core_rsp_valid && !core_rsp_ready) begin
                stall_cnt++;
            end
            cyc++;
            pending = rsp_q.size() + mreq_q.size();
        end
    end

    always @(posedge done) begin
        $display("checker: %0d reads, %0d writes, %0d compares, %0d errors",
                 reads, writes, checks, errors);
    end

endmodule

// ==== cache_bank_sva.sv ====
`timescale 1ns/100ps

module cache_bank_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 core_req_ready,
    input logic                 core_rsp_valid,
    input cache_pkg::core_rsp_t core_rsp,
    input logic                 core_rsp_ready,
    input logic                 mem_req_valid,
    input cache_pkg::mem_req_t  mem_req,
    input logic                 mem_req_ready,
    input logic                 mem_rsp_ready
);
    int fail_count = 0;

    // a held response keeps its value until taken
    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
    else begin
        fail_count++;
        $error("core response changed while stalled");
    end

    mreq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
        fail_count++;
        $error("memory request changed while stalled");
    end

    // fill return only while core requests are blocked
    rsp_vs_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rsp_ready && core_req_ready))
    else begin
        fail_count++;
        $error("mem_rsp_ready and core_req_ready high together");
    end

endmodule

bind cache_bank cache_bank_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_req_ready (core_req_ready),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp       (core_rsp),
    .core_rsp_ready (core_rsp_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_ready  (mem_rsp_ready)
);

// ==== cache_bank.sv ====
`timescale 1ns/100ps

module cache_bank (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             core_req_valid,
    input  cache_pkg::core_req_t             core_req,
    output logic                             core_req_ready,

    output logic                             core_rsp_valid,
    output cache_pkg::core_rsp_t             core_rsp,
    input  logic                             core_rsp_ready,

    output logic                             mem_req_valid,
    output cache_pkg::mem_req_t              mem_req,
    input  logic                             mem_req_ready,

    input  logic                             mem_rsp_valid,
    input  logic [cache_pkg::line_width-1:0] mem_rsp_data,
    output logic                             mem_rsp_ready
);
    import cache_pkg::*;

    // tag store
    logic [line_sel_bits-1:0] tag_line;
    logic [tag_sel_bits-1:0]  tag_lookup;
    logic                     tags_init;
    logic                     tags_fill;
    logic                     hit;

    // data store
    logic [line_sel_bits-1:0] data_line;
    logic [word_sel_bits-1:0] word_sel;
    logic [word_bytes-1:0]    word_byteen;
    logic [word_width-1:0]    write_word;
    logic                     write_hit;
    logic [line_width-1:0]    fill_line;
    logic                     fill_en;
    logic                     read_en;
    logic [line_width-1:0]    read_line;

    // memory request queue
    logic     push;
    mem_req_t push_req;
    logic     alm_full;

    bank_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_ready  (mem_rsp_ready),
        .tag_line       (tag_line),
        .tag_lookup     (tag_lookup),
        .tags_init      (tags_init),
        .tags_fill      (tags_fill),
        .hit            (hit),
        .data_line      (data_line),
        .word_sel       (word_sel),
        .word_byteen    (word_byteen),
        .write_word     (write_word),
        .write_hit      (write_hit),
        .fill_line      (fill_line),
        .fill_en        (fill_en),
        .read_en        (read_en),
        .read_line      (read_line),
        .push           (push),
        .push_req       (push_req),
        .alm_full       (alm_full)
    );

    cache_tags u_tags (
        .clk        (clk),
        .rst_n      (rst_n),
        .tag_line   (tag_line),
        .tag_lookup (tag_lookup),
        .tags_init  (tags_init),
        .tags_fill  (tags_fill),
        .hit        (hit)
    );

    cache_data u_data (
        .clk         (clk),
        .data_line   (data_line),
        .word_sel    (word_sel),
        .word_byteen (word_byteen),
        .write_word  (write_word),
        .write_hit   (write_hit),
        .fill_line   (fill_line),
        .fill_en     (fill_en),
        .read_en     (read_en),
        .read_line   (read_line)
    );

    // empty only feeds mem_req_valid inside the queue
    mem_req_queue u_mreq (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_req      (push_req),
        .mem_req_ready (mem_req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .empty         (),
        .alm_full      (alm_full)
    );

endmodule

// ==== bank_ctrl.sv ====
`timescale 1ns/100ps

module bank_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                core_req_valid,
    input  cache_pkg::core_req_t                core_req,
    output logic                                core_req_ready,

    output logic                                core_rsp_valid,
    output cache_pkg::core_rsp_t                core_rsp,
    input  logic                                core_rsp_ready,

    input  logic                                mem_rsp_valid,
    input  logic [cache_pkg::line_width-1:0]    mem_rsp_data,
    output logic                                mem_rsp_ready,

    output logic [cache_pkg::line_sel_bits-1:0] tag_line,
    output logic [cache_pkg::tag_sel_bits-1:0]  tag_lookup,
    output logic                                tags_init,
    output logic                                tags_fill,
    input  logic                                hit,

    output logic [cache_pkg::line_sel_bits-1:0] data_line,
    output logic [cache_pkg::word_sel_bits-1:0] word_sel,
    output logic [cache_pkg::word_bytes-1:0]    word_byteen,
    output logic [cache_pkg::word_width-1:0]    write_word,
    output logic                                write_hit,
    output logic [cache_pkg::line_width-1:0]    fill_line,
    output logic                                fill_en,
    output logic                                read_en,
    input  logic [cache_pkg::line_width-1:0]    read_line,

    output logic                                push,
    output cache_pkg::mem_req_t                 push_req,
    input  logic                                alm_full
);
    import cache_pkg::*;

    bank_state_e              state;
    logic [line_sel_bits-1:0] init_cnt;

    // miss slot, at most one fill outstanding
    logic [line_addr_width-1:0] miss_addr;
    logic [word_sel_bits-1:0]   miss_wsel;
    logic [req_tag_width-1:0]   miss_tag;

    stage_t st0;
    stage_t st0_next;

    logic                     st1_valid;
    logic                     st1_fill;
    logic [word_sel_bits-1:0] st1_wsel;
    core_rsp_t                st1_rsp;

    logic stall;
    logic adv;
    logic st0_read;
    logic st0_write;
    logic st0_miss;
    logic core_req_fire;
    logic mem_rsp_fire;

    logic [words_per_line-1:0][word_width-1:0] st0_words;
    logic [words_per_line-1:0][word_width-1:0] rd_words;

    // a held response freezes both stages
    assign stall = core_rsp_valid && !core_rsp_ready;
    assign adv   = !stall;

    assign st0_read  = (st0.op == op_read);
    assign st0_write = (st0.op == op_write);
    assign st0_miss  = st0_read && !hit;

    assign core_req_ready = (state == ready) && !st0_miss && !alm_full && !stall;
    assign mem_rsp_ready  = (state == miss_wait) && !stall;

    assign core_req_fire = core_req_valid && core_req_ready;
    assign mem_rsp_fire  = mem_rsp_valid && mem_rsp_ready;

    // init sweep, then fill, then core request
    always_comb begin
        st0_next = '0;
        if (state == init) begin
            st0_next.op   = op_init;
            st0_next.addr = line_addr_width'(init_cnt);
        end else if (mem_rsp_fire) begin
            st0_next.op   = op_fill;
            st0_next.addr = miss_addr;
            st0_next.wsel = miss_wsel;
            st0_next.tag  = miss_tag;
            st0_next.data = mem_rsp_data;
        end else if (core_req_fire) begin
            st0_next.op     = core_req.rw ? op_write : op_read;
            st0_next.addr   = core_req.addr;
            st0_next.wsel   = core_req.wsel;
            st0_next.byteen = core_req.byteen;
            st0_next.tag    = core_req.tag;
            st0_next.data   = line_width'(core_req.data);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= init;
            init_cnt  <= '0;
            st0       <= '0;
            st1_valid <= 1'b0;
            st1_fill  <= 1'b0;
        end else if (adv) begin
            case (state)
                init: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == line_sel_bits'(num_lines - 1)) begin
                        state <= ready;
                    end
                end
                ready: begin
                    if (st0_miss) begin
                        state <= miss_wait;
                    end
                end
                miss_wait: begin
                    if (mem_rsp_fire) begin
                        state <= fill;
                    end
                end
                fill: begin
                    state <= ready;
                end
            endcase
            st0       <= st0_next;
            st1_valid <= (st0_read && hit) || (st0.op == op_fill);
            st1_fill  <= (st0.op == op_fill);
        end
    end

    assign st0_words = st0.data;

    always_ff @(posedge clk) begin
        if (adv && st0_miss) begin
            miss_addr <= st0.addr;
            miss_wsel <= st0.wsel;
            miss_tag  <= st0.tag;
        end
        if (adv) begin
            st1_wsel     <= st0.wsel;
            st1_rsp.tag  <= st0.tag;
            st1_rsp.data <= st0_words[st0.wsel];
        end
    end

    // hits read the registered line, fills answer from their own data
    assign rd_words       = read_line;
    assign core_rsp_valid = st1_valid;

    always_comb begin
        core_rsp.tag  = st1_rsp.tag;
        core_rsp.data = st1_fill ? st1_rsp.data : rd_words[st1_wsel];
    end

    assign tag_line   = st0.addr[line_sel_bits-1:0];
    assign tag_lookup = st0.addr[line_addr_width-1:line_sel_bits];
    assign tags_init  = adv && (st0.op == op_init);
    assign tags_fill  = adv && (st0.op == op_fill);

    assign data_line   = st0.addr[line_sel_bits-1:0];
    assign word_sel    = st0.wsel;
    assign word_byteen = st0.byteen;
    assign write_word  = st0.data[word_width-1:0];
    assign write_hit   = adv && st0_write && hit;
    assign fill_line   = st0.data;
    assign fill_en     = adv && (st0.op == op_fill);
    assign read_en     = adv;

    // write-through on every write, fill request on a read miss
    assign push = adv && (st0_write || st0_miss);

    always_comb begin
        push_req.rw     = st0_write;
        push_req.addr   = st0.addr;
        push_req.data   = {words_per_line{write_word}};
        push_req.byteen = '1;
        if (st0_write) begin
            push_req.byteen = line_bytes'(st0.byteen) << (st0.wsel * word_bytes);
        end
    end

endmodule

// ==== mem_req_queue.sv ====
`timescale 1ns/100ps

module mem_req_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  cache_pkg::mem_req_t push_req,
    input  logic                mem_req_ready,
    output logic                mem_req_valid,
    output cache_pkg::mem_req_t mem_req,
    output logic                empty,
    output logic                alm_full
);
    import cache_pkg::*;

    mem_req_t                      entries [mreq_depth];
    logic [$clog2(mreq_depth)-1:0] wr_ptr;
    logic [$clog2(mreq_depth)-1:0] rd_ptr;
    logic [$clog2(mreq_depth):0]   count;
    logic                          pop;

    assign pop = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    assign empty         = (count == '0);
    assign mem_req_valid = !empty;
    assign mem_req       = entries[rd_ptr];
    // two slots kept free for requests still in the pipeline
    assign alm_full      = (count >= ($clog2(mreq_depth) + 1)'(mreq_alm_full));

endmodule

// ==== cache_data.sv ====
`timescale 1ns/100ps

module cache_data (
    input  logic                                clk,
    input  logic [cache_pkg::line_sel_bits-1:0] data_line,
    input  logic [cache_pkg::word_sel_bits-1:0] word_sel,
    input  logic [cache_pkg::word_bytes-1:0]    word_byteen,
    input  logic [cache_pkg::word_width-1:0]    write_word,
    input  logic                                write_hit,
    input  logic [cache_pkg::line_width-1:0]    fill_line,
    input  logic                                fill_en,
    input  logic                                read_en,
    output logic [cache_pkg::line_width-1:0]    read_line
);
    import cache_pkg::*;

    logic [words_per_line-1:0][word_width-1:0] lines [num_lines];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            lines[data_line] <= fill_line;
        end else if (write_hit) begin
            // merge the word under its byte enables
            for (int b = 0; b < word_bytes; b++) begin
                if (word_byteen[b]) begin
                    lines[data_line][word_sel][b*8 +: 8] <= write_word[b*8 +: 8];
                end
            end
        end
    end

    // holds while the pipeline is stalled
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_line <= lines[data_line];
        end
    end

endmodule

// ==== cache_tags.sv ====
`timescale 1ns/100ps

module cache_tags (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [cache_pkg::line_sel_bits-1:0] tag_line,
    input  logic [cache_pkg::tag_sel_bits-1:0]  tag_lookup,
    input  logic                                tags_init,
    input  logic                                tags_fill,
    output logic                                hit
);
    import cache_pkg::*;

    logic [num_lines-1:0]    valid_q;
    logic [tag_sel_bits-1:0] tag_q [num_lines];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (tags_init) begin
            valid_q[tag_line] <= 1'b0;
        end else if (tags_fill) begin
            valid_q[tag_line] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tags_fill) begin
            tag_q[tag_line] <= tag_lookup;
        end
    end

    // combinational compare, sees all earlier updates
    assign hit = valid_q[tag_line] && (tag_q[tag_line] == tag_lookup);

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

    // word and line geometry
    localparam int word_width      = 32;
    localparam int word_bytes      = 4;
    localparam int words_per_line  = 4;
    localparam int line_width      = 128;
    localparam int line_bytes      = 16;
    localparam int num_lines       = 16;
    localparam int line_sel_bits   = 4;
    localparam int word_sel_bits   = 2;
    localparam int line_addr_width = 10;
    localparam int tag_sel_bits    = 6;
    localparam int req_tag_width   = 8;

    // memory request queue, leaves room for both stages in flight
    localparam int mreq_depth      = 4;
    localparam int pipeline_stages = 2;
    localparam int mreq_alm_full   = mreq_depth - pipeline_stages;

    typedef enum logic [1:0] {
        init,
        ready,
        miss_wait,
        fill
    } bank_state_e;

    typedef enum logic [2:0] {
        op_none,
        op_init,
        op_read,
        op_write,
        op_fill
    } op_e;

    typedef struct packed {
        logic [line_addr_width-1:0] addr;
        logic                       rw;
        logic [word_sel_bits-1:0]   wsel;
        logic [word_bytes-1:0]      byteen;
        logic [word_width-1:0]      data;
        logic [req_tag_width-1:0]   tag;
    } core_req_t;

    typedef struct packed {
        logic [word_width-1:0]    data;
        logic [req_tag_width-1:0] tag;
    } core_rsp_t;

    typedef struct packed {
        logic                       rw;
        logic [line_addr_width-1:0] addr;
        logic [line_bytes-1:0]      byteen;
        logic [line_width-1:0]      data;
    } mem_req_t;

    // write word sits in the low bits of data
    typedef struct packed {
        op_e                        op;
        logic [line_addr_width-1:0] addr;
        logic [word_sel_bits-1:0]   wsel;
        logic [word_bytes-1:0]      byteen;
        logic [req_tag_width-1:0]   tag;
        logic [line_width-1:0]      data;
    } stage_t;

endpackage
